// File: sim.f
+incdir+design
design/rx_phy_pkg.sv
design/rx_sample_pkg.sv
design/rx_ddr_capture.sv
design/rx_deframer.sv
design/rx_enable_timer.sv
design/rx_ctrl_fsm.sv
design/ad9361_rx_top.sv
testbench/ad9361_rx_asserts.sv
testbench/ad9361_rx_tb.sv

// File: Makefile
# Verilator build and run of the AD9361 receive front end testbench

VERILATOR ?= verilator
TOP       ?= ad9361_rx_tb
# 49991 is 32'hc347
SEED      ?= 49991
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, pass if TEST PASSED is printed"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED) OBJ_DIR=$(OBJ_DIR)"

test:
	$(VERILATOR) --binary --assert --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f sim.f
	@out=$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 2>&1); \
		echo "$$out"; \
		echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/ad9361_rx_tb.sv
/* testbench for the AD9361 receive front end
   random DDR pin stimulus, bound assertions do the checking */

`timescale 1ns/1ps

`include "rx_defines.svh"

module ad9361_rx_tb;

  import rx_phy_pkg::*;
  import rx_sample_pkg::*;

  parameter int unsigned SEED = 32'hc347;

  localparam int RESET_CYCLES = 16;
  localparam int FIRST_PAIRS  = 140;
  localparam int BAD_PAIRS    = 40;
  localparam int SECOND_PAIRS = 120;
  // reset, two enable sequences, every data pair and some slack
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * (`RX_COUNT_MAX + 1)
                                  + FIRST_PAIRS + BAD_PAIRS + SECOND_PAIRS + 40;

  logic     rx_clk = 1'b0;
  logic     rst_n  = 1'b0;
  logic     rearm  = 1'b0;
  rx_pins_t pins   = '0;
  logic     enable;
  rx_chan_t chan_0;
  rx_chan_t chan_1;
  logic     frame_err;
  integer   seed   = SEED;
  int       cycles = 0;

  ad9361_rx_top uut (
    .rx_clk    (rx_clk),
    .rst_n     (rst_n),
    .pins      (pins),
    .rearm     (rearm),
    .enable    (enable),
    .chan_0    (chan_0),
    .chan_1    (chan_1),
    .frame_err (frame_err)
  );

  always #10 rx_clk = ~rx_clk;

  function automatic rx_pins_t random_half(input logic frame);
    rx_pins_t    half;
    logic [31:0] r;
    r          = $random(seed);
    half.frame = frame;
    half.p0    = r[`RX_SAMPLE_W-1:0];
    half.p1    = r[16 +: `RX_SAMPLE_W];
    return half;
  endfunction

  // the posedge value is taken as the falling half, the negedge one as the rising half
  task automatic drive_pair(input logic fall_frame, input logic rise_frame,
                            input logic arm);
    @(posedge rx_clk);
    rearm <= arm;
    pins  <= random_half(fall_frame);
    @(negedge rx_clk);
    pins  <= random_half(rise_frame);
  endtask

  initial begin : stimulus
    logic [31:0] frames;
    repeat (RESET_CYCLES) @(posedge rx_clk);
    rst_n <= 1'b1;
    // framed data through the first enable sequence and into RUN
    repeat (FIRST_PAIRS) drive_pair(1'b1, 1'b0, 1'b0);
    // swapped frame levels, then all four patterns at random
    repeat (8) drive_pair(1'b0, 1'b1, 1'b0);
    repeat (BAD_PAIRS - 8) begin
      frames = $random(seed);
      drive_pair(frames[0], frames[1], 1'b0);
    end
    // restart the enable sequence from RUN
    drive_pair(1'b1, 1'b0, 1'b1);
    repeat (SECOND_PAIRS) drive_pair(1'b1, 1'b0, 1'b0);
    // flush the two-cycle pipeline, end between edges
    repeat (4) @(posedge rx_clk);
    @(negedge rx_clk);
    if (uut.u_asserts.fail_count != 0) begin
      $display("TEST FAILED");
      $fatal(1, "%0d assertion failures", uut.u_asserts.fail_count);
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // stop at the first assertion failure
  always @(negedge rx_clk) begin
    if (uut.u_asserts.fail_count != 0) begin
      $display("TEST FAILED");
      $fatal(1, "an assertion failed before %0t", $time);
    end
  end

  always @(posedge rx_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("TEST FAILED");
      $fatal(1, "the run hung, no end after %0d cycles", cycles);
    end
  end

endmodule

// File: testbench/ad9361_rx_asserts.sv
/* concurrent checks for the AD9361 receive front end
   enable timing, valid gating, IQ pairing and frame errors */

`timescale 1ns/1ps

`include "rx_defines.svh"

module ad9361_rx_asserts (
  input logic                    rx_clk,
  input logic                    rst_n,
  input rx_phy_pkg::rx_pins_t    pins,
  input logic                    rearm,
  input logic                    enable,
  input rx_sample_pkg::rx_chan_t chan_0,
  input rx_sample_pkg::rx_chan_t chan_1,
  input logic                    frame_err
);

  import rx_phy_pkg::*;
  import rx_sample_pkg::*;

  // timer load to sampled output adds a register and a sample
  localparam int unsigned ENABLE_ON  = `RX_RESET_DELAY + 2;
  localparam int unsigned ENABLE_OFF = `RX_COUNT_MAX + 2;

  int unsigned fail_count = 0;
  int unsigned since_load;
  logic        started;
  logic        valid_ok;
  rx_half_t    fall_pins;
  rx_ddr_t     pair_d1;
  rx_ddr_t     pair_d2;
  logic        exp_enable;
  logic        exp_valid;
  logic        exp_err;
  iq_t         exp_iq_0;
  iq_t         exp_iq_1;

  ////////////////////////////////////////////////////////////
  // expected behavior
  ////////////////////////////////////////////////////////////

  always_ff @(negedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      fall_pins <= '0;
    end else begin
      fall_pins <= pins;
    end
  end

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_d1    <= '0;
      pair_d2    <= '0;
      since_load <= 0;
      started    <= 1'b0;
      valid_ok   <= 1'b0;
    end else begin
      pair_d1.fall <= fall_pins;
      pair_d1.rise <= pins;
      pair_d2      <= pair_d1;
      started      <= 1'b1;
      // sequencer in RUN from ENABLE_OFF on, valid one cycle behind
      valid_ok     <= (since_load >= ENABLE_OFF);
      if (!started || rearm) begin
        since_load <= 1;
      end else if (since_load != 0 && since_load < ENABLE_OFF) begin
        since_load <= since_load + 1;
      end
    end
  end

  assign exp_enable = (since_load >= ENABLE_ON) && (since_load < ENABLE_OFF);
  assign exp_valid  = pair_d2.fall.frame && !pair_d2.rise.frame && valid_ok;
  assign exp_err    = !pair_d2.fall.frame && pair_d2.rise.frame;
  assign exp_iq_0.i = pair_d2.fall.p0;
  assign exp_iq_0.q = pair_d2.fall.p1;
  assign exp_iq_1.i = pair_d2.rise.p0;
  assign exp_iq_1.q = pair_d2.rise.p1;

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge rx_clk)
    $rose(rst_n) |-> !enable && !chan_0.valid && !chan_1.valid && !frame_err)
  else begin
    fail_count++;
    $error("outputs were not all low when reset was released");
  end

  a_enable: assert property (@(posedge rx_clk) disable iff (!rst_n)
    enable == exp_enable)
  else begin
    fail_count++;
    $error("** Error %0t: enable = %b, expected %b",
           $time, $sampled(enable), $sampled(exp_enable));
  end

  a_valid: assert property (@(posedge rx_clk) disable iff (!rst_n)
    chan_0.valid == exp_valid && chan_1.valid == exp_valid)
  else begin
    fail_count++;
    $error("** Error %0t: chan_0.valid = %b, chan_1.valid = %b, expected %b",
           $time, $sampled(chan_0.valid), $sampled(chan_1.valid), $sampled(exp_valid));
  end

  a_iq_0: assert property (@(posedge rx_clk) disable iff (!rst_n)
    chan_0.valid |-> chan_0.iq == exp_iq_0)
  else begin
    fail_count++;
    $error("** Error %0t: chan_0.iq = %h, expected %h",
           $time, $sampled(chan_0.iq), $sampled(exp_iq_0));
  end

  a_iq_1: assert property (@(posedge rx_clk) disable iff (!rst_n)
    chan_1.valid |-> chan_1.iq == exp_iq_1)
  else begin
    fail_count++;
    $error("** Error %0t: chan_1.iq = %h, expected %h",
           $time, $sampled(chan_1.iq), $sampled(exp_iq_1));
  end

  a_frame_err: assert property (@(posedge rx_clk) disable iff (!rst_n)
    frame_err == exp_err)
  else begin
    fail_count++;
    $error("** Error %0t: frame_err = %b, expected %b",
           $time, $sampled(frame_err), $sampled(exp_err));
  end

  // the sample path closes on the second cycle after rearm
  a_rearm_drop: assert property (@(posedge rx_clk) disable iff (!rst_n)
    $past(rearm, 2) |-> !chan_0.valid && !chan_1.valid)
  else begin
    fail_count++;
    $error("valid was still high two cycles after a rearm pulse");
  end

endmodule

bind ad9361_rx_top ad9361_rx_asserts u_asserts (
  .rx_clk    (rx_clk),
  .rst_n     (rst_n),
  .pins      (pins),
  .rearm     (rearm),
  .enable    (enable),
  .chan_0    (chan_0),
  .chan_1    (chan_1),
  .frame_err (frame_err)
);

// File: design/ad9361_rx_top.sv
/* AD9361 CMOS dual-port receive front end, RX only
   capture, deframing and radio enable sequencing on rx_clk */

`timescale 1ns/1ps

module ad9361_rx_top (
  input  logic                    rx_clk,
  input  logic                    rst_n,
  input  rx_phy_pkg::rx_pins_t    pins,
  input  logic                    rearm,
  output logic                    enable,
  output rx_sample_pkg::rx_chan_t chan_0,
  output rx_sample_pkg::rx_chan_t chan_1,
  output logic                    frame_err
);

  import rx_phy_pkg::*;

  rx_ddr_t ddr;
  logic    load;
  logic    in_window;
  logic    done;
  logic    rx_active;

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  rx_ddr_capture u_capture (
    .rx_clk (rx_clk),
    .rst_n  (rst_n),
    .pins   (pins),
    .ddr    (ddr)
  );

  rx_deframer u_deframer (
    .rx_clk    (rx_clk),
    .rst_n     (rst_n),
    .ddr       (ddr),
    .rx_active (rx_active),
    .chan_0    (chan_0),
    .chan_1    (chan_1),
    .frame_err (frame_err)
  );

  ////////////////////////////////////////////////////////////
  // radio enable control
  ////////////////////////////////////////////////////////////

  rx_enable_timer u_timer (
    .rx_clk    (rx_clk),
    .rst_n     (rst_n),
    .load      (load),
    .in_window (in_window),
    .done      (done)
  );

  rx_ctrl_fsm u_ctrl (
    .rx_clk    (rx_clk),
    .rst_n     (rst_n),
    .rearm     (rearm),
    .in_window (in_window),
    .done      (done),
    .load      (load),
    .enable    (enable),
    .rx_active (rx_active)
  );

endmodule

// File: design/rx_ctrl_fsm.sv
/* radio enable sequencer, loads the timer after reset or rearm
   and opens the sample path once the enable pulse is over */

`timescale 1ns/1ps

module rx_ctrl_fsm (
  input  logic rx_clk,
  input  logic rst_n,
  input  logic rearm,
  input  logic in_window,
  input  logic done,
  output logic load,
  output logic enable,
  output logic rx_active
);

  import rx_sample_pkg::*;

  rx_state_t state;
  rx_state_t state_nxt;

  // IDLE only lasts the first cycle out of reset
  assign load = (state == IDLE) || rearm;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:  state_nxt = DELAY;
      DELAY: if (in_window) state_nxt = PULSE;
      PULSE: if (done) state_nxt = RUN;
      RUN:   state_nxt = RUN;
      default: state_nxt = IDLE;
    endcase
    // restart the sequence from any active state
    if (rearm && state != IDLE) begin
      state_nxt = DELAY;
    end
  end

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      enable <= 1'b0;
    end else begin
      state  <= state_nxt;
      enable <= in_window && !rearm && (state == DELAY || state == PULSE);
    end
  end

  assign rx_active = (state == RUN);

endmodule

// File: design/rx_enable_timer.sv
/* down counter timing the radio reset delay and the enable window */

`timescale 1ns/1ps

`include "rx_defines.svh"

module rx_enable_timer (
  input  logic rx_clk,
  input  logic rst_n,
  input  logic load,
  output logic in_window,
  output logic done
);

  localparam int CNT_W = $clog2(`RX_COUNT_MAX + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_W'(`RX_COUNT_MAX);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // last RX_ENABLE_CYCLES counts before zero
  assign in_window = (count != '0) && (count <= CNT_W'(`RX_ENABLE_CYCLES));
  assign done      = (count == '0);

endmodule

// File: design/rx_deframer.sv
/* pairs the captured halves into channel 0 and channel 1 IQ samples
   valid from the rx_frame pattern, frame_err on inverted framing */

`timescale 1ns/1ps

module rx_deframer (
  input  logic                    rx_clk,
  input  logic                    rst_n,
  input  rx_phy_pkg::rx_ddr_t     ddr,
  input  logic                    rx_active,
  output rx_sample_pkg::rx_chan_t chan_0,
  output rx_sample_pkg::rx_chan_t chan_1,
  output logic                    frame_err
);

  import rx_sample_pkg::*;

  logic good_frame;
  logic bad_frame;
  logic valid_q;
  iq_t  iq_0_q;
  iq_t  iq_1_q;

  // frame high on the falling half, low on the rising half
  assign good_frame = ddr.fall.frame & ~ddr.rise.frame;
  // swapped halves
  assign bad_frame  = ~ddr.fall.frame & ddr.rise.frame;

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      // samples are dropped until the radio is running
      valid_q   <= good_frame & rx_active;
      frame_err <= bad_frame;
    end
  end

  // sample payload
  always_ff @(posedge rx_clk) begin
    iq_0_q.i <= ddr.fall.p0;
    iq_0_q.q <= ddr.fall.p1;
    iq_1_q.i <= ddr.rise.p0;
    iq_1_q.q <= ddr.rise.p1;
  end

  assign chan_0.valid = valid_q;
  assign chan_0.iq    = iq_0_q;
  assign chan_1.valid = valid_q;
  assign chan_1.iq    = iq_1_q;

endmodule

// File: design/rx_ddr_capture.sv
/* generic DDR capture of both AD9361 data ports and rx_frame
   falling half re-timed so both halves update on the rising edge */

`timescale 1ns/1ps

module rx_ddr_capture (
  input  logic                 rx_clk,
  input  logic                 rst_n,
  input  rx_phy_pkg::rx_pins_t pins,
  output rx_phy_pkg::rx_ddr_t  ddr
);

  import rx_phy_pkg::*;

  rx_half_t fall_q;

  ////////////////////////////////////////////////////////////
  // falling edge, channel 0 half
  ////////////////////////////////////////////////////////////

  always_ff @(negedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      fall_q <= '0;
    end else begin
      fall_q <= pins;
    end
  end

  ////////////////////////////////////////////////////////////
  // rising edge, channel 1 half
  ////////////////////////////////////////////////////////////

  // fall_q here is the half from the negedge just before this edge,
  // so the pair leaves together
  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      ddr <= '0;
    end else begin
      ddr.fall <= fall_q;
      ddr.rise <= pins;
    end
  end

endmodule

// File: design/rx_sample_pkg.sv
/* AD9361 receive sample types
   deframed IQ samples and the enable sequencer states */

`include "rx_defines.svh"

package rx_sample_pkg;

  // port 0 is I, port 1 is Q
  typedef struct packed {
    logic [`RX_SAMPLE_W-1:0] i;
    logic [`RX_SAMPLE_W-1:0] q;
  } iq_t;

  // one channel output with its strobe
  typedef struct packed {
    logic valid;
    iq_t  iq;
  } rx_chan_t;

  // radio enable sequence
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    DELAY = 2'd1,
    PULSE = 2'd2,
    RUN   = 2'd3
  } rx_state_t;

endpackage

// File: design/rx_phy_pkg.sv
/* AD9361 receive pin types
   pin bundle and the half-words captured on each clock edge */

`include "rx_defines.svh"

package rx_phy_pkg;

  // frame and both data ports as seen on the pins
  typedef struct packed {
    logic                     frame;
    logic [`RX_SAMPLE_W-1:0]  p0;
    logic [`RX_SAMPLE_W-1:0]  p1;
  } rx_pins_t;

  // one half-word, same layout as the pins
  typedef struct packed {
    logic                     frame;
    logic [`RX_SAMPLE_W-1:0]  p0;
    logic [`RX_SAMPLE_W-1:0]  p1;
  } rx_half_t;

  // fall is channel 0, rise is channel 1
  typedef struct packed {
    rx_half_t fall;
    rx_half_t rise;
  } rx_ddr_t;

endpackage

// File: design/rx_defines.svh
/* AD9361 receive front end
   widths, enable sequence timing and counter load value */

`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

// port and sample width, CMOS dual-port mode
`define RX_SAMPLE_W 12

// cycles from timer load to start of the enable pulse
`define RX_RESET_DELAY 16

// length of the enable pulse
`define RX_ENABLE_CYCLES 4

// timer load value, delay plus pulse
`define RX_COUNT_MAX (`RX_RESET_DELAY + `RX_ENABLE_CYCLES)

`endif
